// ==== stereo_cfg.svh ====
`ifndef STEREO_CFG_SVH
`define STEREO_CFG_SVH

// ------------------------------------------------------------
// Frame store window
// ------------------------------------------------------------

// Window kept per camera, top-left corner of the sensor frame
`define MEM_X_SIZE 16
`define MEM_Y_SIZE 8

// Coordinate widths inside the window
// The x size must be a power of two, its top bit picks the camera on readout
`define MEM_X_BITS 4
`define MEM_Y_BITS 3

// ------------------------------------------------------------
// Pixel and counters
// ------------------------------------------------------------

// Raw sensor pixel
`define PIXEL_BITS 10

// Full-frame coordinate counters
`define CNT_BITS 14

// Arbiter rotation: cam0 write, cam1 write, readout
`define ARB_SLOTS 3

`endif

// ==== stereo_pkg.sv ====
`default_nettype none

`include "stereo_cfg.svh"

package stereo_pkg;

    // ------------------------------------------------------------
    // Basic words
    // ------------------------------------------------------------

    typedef logic [`PIXEL_BITS-1:0] pixel_t;

    // One frame-store location, camera select on top
    typedef struct packed {
        logic                   cam;
        logic [`MEM_Y_BITS-1:0] y;
        logic [`MEM_X_BITS-1:0] x;
    } mem_addr_t;

    // ------------------------------------------------------------
    // Bundles between blocks
    // ------------------------------------------------------------

    // Sensor side, pixel qualified by its own strobe
    typedef struct packed {
        logic   fv;
        logic   lv;
        logic   pix_valid;
        pixel_t pixel;
    } cam_in_t;

    // Capture unit write request, level until acked
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        pixel_t    data;
    } mem_wr_t;

    // Readout read request
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
    } mem_rd_t;

    // Side-by-side output pixel
    typedef struct packed {
        logic   valid;
        logic   sof;
        logic   eol;
        pixel_t data;
    } vid_out_t;

endpackage

`default_nettype wire

// ==== cam_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stereo_cfg.svh"

module cam_capture
    import stereo_pkg::*;
    (
        input  var logic    cam_clk,
        input  var logic    sys_reset,

        input  var cam_in_t cam_i,
        input  var logic    cam_sel_i,

        output var mem_wr_t wr_o,
        input  var logic    wr_ack_i
    );

    logic                 lv_prev;
    logic [`CNT_BITS-1:0] x_cnt;
    logic [`CNT_BITS-1:0] y_cnt;
    logic                 pix_take;
    logic                 in_window;

    logic                 wr_valid;
    mem_addr_t            wr_addr;
    pixel_t               wr_data;

    // ------------------------------------------------------------
    // Frame coordinates
    // ------------------------------------------------------------

    assign pix_take  = cam_i.fv && cam_i.lv && cam_i.pix_valid;
    assign in_window = (x_cnt < `MEM_X_SIZE) && (y_cnt < `MEM_Y_SIZE);

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            lv_prev <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            lv_prev <= cam_i.lv;

            // x restarts in the gap between lines
            if (!cam_i.lv) begin
                x_cnt <= '0;
            end else if (pix_take) begin
                x_cnt <= x_cnt + 1'b1;
            end

            // Falling edge of lv ends a line
            if (!cam_i.fv) begin
                y_cnt <= '0;
            end else if (lv_prev && !cam_i.lv) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Pending write
    // ------------------------------------------------------------

    // A fresh pixel wins over the ack of the previous one
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            wr_valid <= 1'b0;
        end else if (pix_take && in_window) begin
            wr_valid <= 1'b1;
        end else if (wr_ack_i) begin
            wr_valid <= 1'b0;
        end
    end

    always_ff @(posedge cam_clk) begin
        if (pix_take && in_window) begin
            wr_addr.cam <= cam_sel_i;
            wr_addr.y   <= y_cnt[`MEM_Y_BITS-1:0];
            wr_addr.x   <= x_cnt[`MEM_X_BITS-1:0];
            wr_data     <= cam_i.pixel;
        end
    end

    assign wr_o.valid = wr_valid;
    assign wr_o.addr  = wr_addr;
    assign wr_o.data  = wr_data;

endmodule

`default_nettype wire

// ==== frame_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stereo_cfg.svh"

module frame_ram (
        input  var logic                                      cam_clk,
        input  var logic                                      en_i,
        input  var logic                                      we_i,
        input  var logic [`MEM_Y_BITS+`MEM_X_BITS:0]          addr_i,
        input  var logic [`PIXEL_BITS-1:0]                    wdata_i,
        output var logic [`PIXEL_BITS-1:0]                    rdata_o
    );

    localparam int WIN_WORDS = `MEM_Y_SIZE * `MEM_X_SIZE;
    localparam int DEPTH     = 2 * WIN_WORDS;
    localparam int IDX_BITS  = $clog2(DEPTH);

    logic [`PIXEL_BITS-1:0] mem [DEPTH];
    logic                   sel;
    logic [`MEM_Y_BITS-1:0] y;
    logic [`MEM_X_BITS-1:0] x;
    logic [IDX_BITS-1:0]    idx;

    // Camera 1 window sits above camera 0 window
    assign {sel, y, x} = addr_i;
    assign idx = IDX_BITS'(sel * WIN_WORDS + y * `MEM_X_SIZE + x);

    always_ff @(posedge cam_clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx] <= wdata_i;
            end else begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stereo_cfg.svh"

module mem_arbiter
    import stereo_pkg::*;
    (
        input  var logic    cam_clk,
        input  var logic    sys_reset,

        input  var mem_wr_t wr0_i,
        output var logic    wr0_ack_o,
        input  var mem_wr_t wr1_i,
        output var logic    wr1_ack_o,

        input  var mem_rd_t rd_i,
        output var logic    rd_ack_o,
        output var logic    rd_data_valid_o,
        output var pixel_t  rd_data_o
    );

    localparam int SLOT_BITS = $clog2(`ARB_SLOTS);

    localparam logic [SLOT_BITS-1:0] SLOT_CAM0 = SLOT_BITS'(0);
    localparam logic [SLOT_BITS-1:0] SLOT_CAM1 = SLOT_BITS'(1);
    localparam logic [SLOT_BITS-1:0] SLOT_READ = SLOT_BITS'(2);
    localparam logic [SLOT_BITS-1:0] SLOT_LAST = SLOT_BITS'(`ARB_SLOTS - 1);

    logic [SLOT_BITS-1:0] slot;

    logic                 ram_en;
    logic                 ram_we;
    mem_addr_t            ram_addr;
    pixel_t               ram_wdata;

    // ------------------------------------------------------------
    // Slot rotation
    // ------------------------------------------------------------

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            slot <= SLOT_CAM0;
        end else if (slot == SLOT_LAST) begin
            slot <= SLOT_CAM0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Port mux
    // ------------------------------------------------------------

    // Owner of the slot gets the store, an idle slot stays idle
    always_comb begin
        ram_en    = 1'b0;
        ram_we    = 1'b0;
        ram_addr  = rd_i.addr;
        ram_wdata = wr0_i.data;
        wr0_ack_o = 1'b0;
        wr1_ack_o = 1'b0;
        rd_ack_o  = 1'b0;

        case (slot)
            SLOT_CAM0: begin
                if (wr0_i.valid) begin
                    ram_en    = 1'b1;
                    ram_we    = 1'b1;
                    ram_addr  = wr0_i.addr;
                    ram_wdata = wr0_i.data;
                    wr0_ack_o = 1'b1;
                end
            end
            SLOT_CAM1: begin
                if (wr1_i.valid) begin
                    ram_en    = 1'b1;
                    ram_we    = 1'b1;
                    ram_addr  = wr1_i.addr;
                    ram_wdata = wr1_i.data;
                    wr1_ack_o = 1'b1;
                end
            end
            SLOT_READ: begin
                if (rd_i.valid) begin
                    ram_en   = 1'b1;
                    ram_addr = rd_i.addr;
                    rd_ack_o = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // Read data returns one cycle after the grant
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            rd_data_valid_o <= 1'b0;
        end else begin
            rd_data_valid_o <= rd_ack_o;
        end
    end

    frame_ram u_frame_ram (
        .cam_clk (cam_clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== stereo_readout.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stereo_cfg.svh"

module stereo_readout
    import stereo_pkg::*;
    (
        input  var logic     cam_clk,
        input  var logic     sys_reset,

        output var mem_rd_t  rd_o,
        input  var logic     rd_ack_i,
        input  var logic     rd_data_valid_i,
        input  var pixel_t   rd_data_i,

        output var vid_out_t vid_o
    );

    localparam int OX_BITS = `MEM_X_BITS + 1;

    localparam logic [OX_BITS-1:0]     X_LAST = OX_BITS'(2 * `MEM_X_SIZE - 1);
    localparam logic [`MEM_Y_BITS-1:0] Y_LAST = `MEM_Y_BITS'(`MEM_Y_SIZE - 1);

    logic [OX_BITS-1:0]     out_x;
    logic [`MEM_Y_BITS-1:0] out_y;
    logic                   rd_valid;
    logic                   sof_pend;
    logic                   eol_pend;

    logic                   vid_valid;
    logic                   vid_sof;
    logic                   vid_eol;
    pixel_t                 vid_data;

    // ------------------------------------------------------------
    // Sweep and read request
    // ------------------------------------------------------------

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            rd_valid <= 1'b0;
            out_x    <= '0;
            out_y    <= '0;
        end else begin
            rd_valid <= 1'b1;
            if (rd_ack_i) begin
                if (out_x == X_LAST) begin
                    out_x <= '0;
                    out_y <= (out_y == Y_LAST) ? '0 : out_y + 1'b1;
                end else begin
                    out_x <= out_x + 1'b1;
                end
            end
        end
    end

    // Left half from camera 0, right half from camera 1
    assign rd_o.valid    = rd_valid;
    assign rd_o.addr.cam = out_x[`MEM_X_BITS];
    assign rd_o.addr.y   = out_y;
    assign rd_o.addr.x   = out_x[`MEM_X_BITS-1:0];

    // Markers of the read in flight
    always_ff @(posedge cam_clk) begin
        if (rd_ack_i) begin
            sof_pend <= (out_x == '0) && (out_y == '0);
            eol_pend <= (out_x == X_LAST);
        end
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            vid_valid <= 1'b0;
        end else begin
            vid_valid <= rd_data_valid_i;
        end
    end

    always_ff @(posedge cam_clk) begin
        if (rd_data_valid_i) begin
            vid_sof  <= sof_pend;
            vid_eol  <= eol_pend;
            vid_data <= rd_data_i;
        end
    end

    assign vid_o.valid = vid_valid;
    assign vid_o.sof   = vid_sof;
    assign vid_o.eol   = vid_eol;
    assign vid_o.data  = vid_data;

endmodule

`default_nettype wire

// ==== stereo_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module stereo_capture_top
    import stereo_pkg::*;
    (
        input  var logic     cam_clk,
        input  var logic     sys_reset,

        input  var cam_in_t  cam0_i,
        input  var cam_in_t  cam1_i,

        output var vid_out_t vid_o
    );

    mem_wr_t wr0;
    logic    wr0_ack;
    mem_wr_t wr1;
    logic    wr1_ack;

    mem_rd_t rd;
    logic    rd_ack;
    logic    rd_data_valid;
    pixel_t  rd_data;

    // ------------------------------------------------------------
    // Capture side
    // ------------------------------------------------------------

    cam_capture u_cam_capture0 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .cam_i     (cam0_i),
        .cam_sel_i (1'b0),
        .wr_o      (wr0),
        .wr_ack_i  (wr0_ack)
    );

    cam_capture u_cam_capture1 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .cam_i     (cam1_i),
        .cam_sel_i (1'b1),
        .wr_o      (wr1),
        .wr_ack_i  (wr1_ack)
    );

    // ------------------------------------------------------------
    // Shared frame store and readout
    // ------------------------------------------------------------

    mem_arbiter u_mem_arbiter (
        .cam_clk         (cam_clk),
        .sys_reset       (sys_reset),
        .wr0_i           (wr0),
        .wr0_ack_o       (wr0_ack),
        .wr1_i           (wr1),
        .wr1_ack_o       (wr1_ack),
        .rd_i            (rd),
        .rd_ack_o        (rd_ack),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data)
    );

    stereo_readout u_stereo_readout (
        .cam_clk         (cam_clk),
        .sys_reset       (sys_reset),
        .rd_o            (rd),
        .rd_ack_i        (rd_ack),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data),
        .vid_o           (vid_o)
    );

endmodule

`default_nettype wire

// ==== tb_stereo_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stereo_cfg.svh"

module tb_stereo_capture
    import stereo_pkg::*;
    ();

    localparam int OUT_W      = 2 * `MEM_X_SIZE;
    localparam int SWEEP_CYC  = 3 * OUT_W * `MEM_Y_SIZE;
    localparam int MAX_FRAMES = 3;
    localparam int MAX_W      = `MEM_X_SIZE + 8;
    localparam int MAX_H      = `MEM_Y_SIZE + 4;
    localparam int NUM_FRAMES = 6;
    localparam int NUM_STAGES = 3;
    localparam int SETTLE_CYC = 8;
    localparam int MARGIN_CYC = 1000;

    logic     cam_clk;
    logic     sys_reset;
    cam_in_t  cam_drv [2];
    vid_out_t vid_o;

    integer   seed;
    int       errors;
    int       value_checks;
    int       cyc;
    int       busy;
    int       last_end_cyc;
    int       sof_count;

    // Shadow of every pixel sent per camera, frame, line and column
    pixel_t   shadow [2][MAX_FRAMES][MAX_H][MAX_W];
    int       n_frames [2];
    int       fw [2][MAX_FRAMES];
    int       fh [2][MAX_FRAMES];

    stereo_capture_top uut (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .cam0_i    (cam_drv[0]),
        .cam1_i    (cam_drv[1]),
        .vid_o     (vid_o)
    );

    initial begin
        cam_clk = 1'b0;
        forever #50 cam_clk = ~cam_clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Drive point 10 ns after the rising edge
    task automatic step();
        @(posedge cam_clk);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step();
    endtask

    function automatic int frame_cycles(input int w, input int h, input int gap);
        return 3 + h * (3 * w + gap) + gap;
    endfunction

    // Latest in-window value for an output position
    // X where nothing was written yet
    function automatic pixel_t expected_pixel(input int x, input int y);
        int     cam;
        int     wx;
        pixel_t result;
        result = 'x;
        cam = (x >= `MEM_X_SIZE) ? 1 : 0;
        wx = x - cam * `MEM_X_SIZE;
        for (int f = 0; f < n_frames[cam]; f++) begin
            if (wx < fw[cam][f] && y < fh[cam][f] && wx < `MEM_X_SIZE && y < `MEM_Y_SIZE) begin
                result = shadow[cam][f][y][wx];
            end
        end
        return result;
    endfunction

    // One sensor frame with a strobe and two idle cycles per pixel
    task automatic send_frame(input int cam, input int w, input int h, input int gap);
        int     f;
        pixel_t pix;
        f = n_frames[cam];
        n_frames[cam]++;
        fw[cam][f] = w;
        fh[cam][f] = h;
        busy++;
        cam_drv[cam].fv = 1'b1;
        idle_cycles(2);
        for (int y = 0; y < h; y++) begin
            cam_drv[cam].lv = 1'b1;
            for (int x = 0; x < w; x++) begin
                pix = pixel_t'($random(seed));
                shadow[cam][f][y][x] = pix;
                cam_drv[cam].pix_valid = 1'b1;
                cam_drv[cam].pixel     = pix;
                step();
                cam_drv[cam].pix_valid = 1'b0;
                idle_cycles(2);
            end
            cam_drv[cam].lv = 1'b0;
            idle_cycles(gap);
        end
        cam_drv[cam].fv = 1'b0;
        last_end_cyc = cyc;
        busy--;
        idle_cycles(gap);
    endtask

    // Let writes settle and one whole sweep pass the compare process
    task automatic wait_clean_sweep();
        int start;
        idle_cycles(SETTLE_CYC + 2);
        start = sof_count;
        wait (sof_count >= start + 2);
        step();
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Run summary: errors=%0d value_checks=%0d sweeps=%0d timeout=%0d",
                 errors, value_checks, sof_count, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin : stimulus
        seed         = 32'h972;
        sys_reset    = 1'b1;
        cam_drv[0]   = '0;
        cam_drv[1]   = '0;
        errors       = 0;
        value_checks = 0;
        cyc          = 0;
        busy         = 0;
        last_end_cyc = 0;
        sof_count    = 0;
        n_frames     = '{0, 0};
        repeat (8) @(posedge cam_clk);
        #10;
        sys_reset = 1'b0;
        idle_cycles(4);

        // Exact window on each camera in turn
        send_frame(0, `MEM_X_SIZE, `MEM_Y_SIZE, 4);
        send_frame(1, `MEM_X_SIZE, `MEM_Y_SIZE, 4);
        wait_clean_sweep();

        // Oversized frames with the same timing on both cameras
        fork
            send_frame(0, `MEM_X_SIZE + 4, `MEM_Y_SIZE + 2, 6);
            send_frame(1, `MEM_X_SIZE + 4, `MEM_Y_SIZE + 2, 6);
        join
        wait_clean_sweep();

        // Skewed start and different line gaps
        fork
            send_frame(0, `MEM_X_SIZE + 2, `MEM_Y_SIZE + 1, 3);
            begin
                idle_cycles(7);
                send_frame(1, `MEM_X_SIZE, `MEM_Y_SIZE, 5);
            end
        join
        wait_clean_sweep();

        assert (value_checks > 0) else begin
            errors++;
            $display("No output pixel was compared against the reference");
        end
        finish_run(1'b0);
    end

    // ------------------------------------------------------------
    // Output compare
    // ------------------------------------------------------------

    initial begin : compare_outputs
        int     last_valid;
        int     px;
        int     py;
        bit     started;
        pixel_t exp_pix;
        started    = 1'b0;
        last_valid = 0;
        px         = 0;
        py         = 0;
        #1;
        wait (sys_reset === 1'b0);
        forever begin
            @(negedge cam_clk);
            cyc++;
            if (cyc <= 2) begin
                assert (vid_o.valid !== 1'b1) else begin
                    errors++;
                    $display("vid_o.valid went high %0d cycles after reset release", cyc);
                end
            end
            if (vid_o.valid === 1'b1) begin
                if (!started) begin
                    assert (vid_o.sof === 1'b1) else begin
                        errors++;
                        $display("First valid output pixel at %0t has no sof marker", $time);
                    end
                    started = 1'b1;
                end else begin
                    assert (cyc - last_valid == 3) else begin
                        errors++;
                        $display("Output pixel at %0t came %0d cycles after the previous one",
                                 $time, cyc - last_valid);
                    end
                    if (px == OUT_W - 1) begin
                        px = 0;
                        py = (py == `MEM_Y_SIZE - 1) ? 0 : py + 1;
                    end else begin
                        px++;
                    end
                    assert (vid_o.sof === ((px == 0 && py == 0) ? 1'b1 : 1'b0)) else begin
                        errors++;
                        $display("Misplaced sof marker at %0t for position x=%0d y=%0d",
                                 $time, px, py);
                    end
                end
                assert (vid_o.eol === ((px == OUT_W - 1) ? 1'b1 : 1'b0)) else begin
                    errors++;
                    $display("Missing or misplaced eol marker at %0t for position x=%0d y=%0d",
                             $time, px, py);
                end
                if (vid_o.sof === 1'b1) begin
                    sof_count++;
                end
                last_valid = cyc;

                // Only once no frame is running and the last writes have landed
                exp_pix = expected_pixel(px, py);
                if (busy == 0 && cyc - last_end_cyc > SETTLE_CYC && !$isunknown(exp_pix)) begin
                    value_checks++;
                    assert (vid_o.data === exp_pix) else begin
                        errors++;
                        $display(
                            "CHECK FAILED time=%0t vid_o.data expected=%h actual=%h x=%0d y=%0d",
                            $time, exp_pix, vid_o.data, px, py);
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------

    initial begin : watchdog
        int limit;
        limit = NUM_FRAMES * frame_cycles(MAX_W, MAX_H, 6)
              + NUM_STAGES * SWEEP_CYC + MARGIN_CYC;
        repeat (limit + 8) @(posedge cam_clk);
        errors++;
        $display("Watchdog expired after %0d cycles, the test sequence did not complete", limit);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
stereo_pkg.sv
cam_capture.sv
frame_ram.sv
mem_arbiter.sv
stereo_readout.sv
stereo_capture_top.sv
tb_stereo_capture.sv
